// ==== verilog/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

  // -------------------
  // widths and counts
  // -------------------
  localparam int block_width = 128;
  localparam int word_width  = 32;
  localparam int num_rounds  = 10;

  typedef logic [block_width-1:0] block_t;  // state or key
  typedef logic [word_width-1:0]  word_t;   // one column
  typedef logic [7:0]             byte_t;

  // -------------------
  // field constants
  // -------------------
  localparam byte_t rcon_init = 8'h01;
  localparam byte_t gf_poly   = 8'h1B;  // x^8 = x^4 + x^3 + x + 1

  // request and response
  typedef struct packed {
    logic   rdy;
    block_t blk;
  } blk_req_t;

  typedef struct packed {
    logic   vld;
    block_t blk;
  } blk_rsp_t;

  // multiply by x in GF(2^8)
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? gf_poly : 8'h00);
  endfunction

endpackage

`default_nettype wire

// ==== verilog/aes_ctrl_pkg.sv ====
`default_nettype none

package aes_ctrl_pkg;

  // round sequencer states
  typedef enum logic [1:0] {
    st_idle,
    st_round,   // rounds 1 to 9
    st_final    // round 10, no mixcolumns
  } seq_state_e;

  // datapath opcodes, one per cycle
  typedef enum logic [2:0] {
    op_hold,
    op_key_load,
    op_data_load,
    op_round,
    op_final
  } dp_op_e;

  typedef struct packed {
    dp_op_e     op;
    logic [7:0] rcon;  // constant for the next round key
  } round_ctl_t;

endpackage

`default_nettype wire

// ==== verilog/gf_inv8.sv ====
`timescale 1ns/1ps
`default_nettype none

module gf_inv8 (
  input  aes_pkg::byte_t x,
  output aes_pkg::byte_t y
);

  // basis change rows, bit 7 row first
  localparam logic [7:0][7:0] to_tower   = {8'hA0, 8'hDE, 8'hAC, 8'hAE,
                                            8'hC6, 8'h9E, 8'h52, 8'h43};
  localparam logic [7:0][7:0] from_tower = {8'hE2, 8'h44, 8'h62, 8'h76,
                                            8'h3E, 8'h9E, 8'h30, 8'h75};

  logic [7:0] xt;
  logic [7:0] yt;
  logic [3:0] hi;
  logic [3:0] lo;
  logic [3:0] hl;
  logic [3:0] d;
  logic [3:0] di;

  function automatic aes_pkg::byte_t basis_map(input aes_pkg::byte_t v,
                                               input logic [7:0][7:0] m);
    aes_pkg::byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = ^(v & m[i]);
    end
    return r;
  endfunction

  // --------------------
  // GF(2^2)
  // --------------------
  function automatic logic [1:0] gf2_sq(input logic [1:0] a);
    return {a[1], a[1] ^ a[0]};
  endfunction

  function automatic logic [1:0] gf2_mul(input logic [1:0] a, input logic [1:0] b);
    return {(a[1] & b[1]) ^ (a[1] & b[0]) ^ (a[0] & b[1]),
            (a[1] & b[1]) ^ (a[0] & b[0])};
  endfunction

  function automatic logic [1:0] gf2_phi(input logic [1:0] a);  // times phi = 2'b10
    return {a[1] ^ a[0], a[1]};
  endfunction

  // --------------------
  // GF(2^4) over GF(2^2)
  // --------------------
  function automatic logic [3:0] gf4_sq(input logic [3:0] a);
    logic [1:0] hs;
    hs = gf2_sq(a[3:2]);
    return {hs, gf2_phi(hs) ^ gf2_sq(a[1:0])};
  endfunction

  function automatic logic [3:0] gf4_mul(input logic [3:0] a, input logic [3:0] b);
    logic [1:0] hh;
    hh = gf2_mul(a[3:2], b[3:2]);
    return {hh ^ gf2_mul(a[3:2], b[1:0]) ^ gf2_mul(a[1:0], b[3:2]),
            gf2_phi(hh) ^ gf2_mul(a[1:0], b[1:0])};
  endfunction

  function automatic logic [3:0] gf4_lambda(input logic [3:0] a);  // times 4'b1100
    return {a[2] ^ a[0], ^a, a[3], a[2]};
  endfunction

  function automatic logic [3:0] gf4_inv(input logic [3:0] a);
    logic [1:0] n;
    logic [1:0] ni;
    n  = gf2_phi(gf2_sq(a[3:2])) ^ gf2_mul(a[3:2] ^ a[1:0], a[1:0]);
    ni = gf2_sq(n);  // square is the inverse in GF(4)
    return {gf2_mul(a[3:2], ni), gf2_mul(a[3:2] ^ a[1:0], ni)};
  endfunction

  // --------------------
  // GF(2^8) inverse in the tower
  // --------------------
  assign xt = basis_map(x, to_tower);
  assign hi = xt[7:4];
  assign lo = xt[3:0];
  assign hl = hi ^ lo;

  assign d  = gf4_lambda(gf4_sq(hi)) ^ gf4_mul(hl, lo);  // norm
  assign di = gf4_inv(d);
  assign yt = {gf4_mul(hi, di), gf4_mul(hl, di)};

  assign y  = basis_map(yt, from_tower);

endmodule

`default_nettype wire

// ==== verilog/sbox_word.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbox_word (
  input  aes_pkg::word_t x,
  output aes_pkg::word_t y
);

  localparam aes_pkg::byte_t affine_c = 8'h63;

  wire aes_pkg::word_t inv;

  // b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
  function automatic aes_pkg::byte_t affine(input aes_pkg::byte_t s);
    return s ^ {s[6:0], s[7]} ^ {s[5:0], s[7:6]} ^ {s[4:0], s[7:5]}
             ^ {s[3:0], s[7:4]} ^ affine_c;
  endfunction

  for (genvar i = 0; i < 4; i++) begin : g_byte
    gf_inv8 u_inv (
      .x (x[8*i +: 8]),
      .y (inv[8*i +: 8])
    );
  end

  assign y = {affine(inv[31:24]), affine(inv[23:16]),
              affine(inv[15:8]), affine(inv[7:0])};

endmodule

`default_nettype wire

// ==== verilog/aes_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_round (
  input  aes_pkg::block_t state_in,
  input  aes_pkg::block_t round_key,
  input  logic            last,       // final round, skip mixcolumns
  output aes_pkg::block_t state_out
);

  aes_pkg::word_t sb_col  [4];
  aes_pkg::word_t sr_col  [4];
  aes_pkg::word_t mc_col  [4];
  aes_pkg::word_t ark_col [4];

  // 2a0 ^ 3a1 ^ a2 ^ a3 per row, rotated
  function automatic aes_pkg::word_t mix_col(input aes_pkg::word_t w);
    aes_pkg::byte_t a0;
    aes_pkg::byte_t a1;
    aes_pkg::byte_t a2;
    aes_pkg::byte_t a3;
    aes_pkg::byte_t t;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    t  = a0 ^ a1 ^ a2 ^ a3;
    return {a0 ^ t ^ aes_pkg::xtime(a0 ^ a1),
            a1 ^ t ^ aes_pkg::xtime(a1 ^ a2),
            a2 ^ t ^ aes_pkg::xtime(a2 ^ a3),
            a3 ^ t ^ aes_pkg::xtime(a3 ^ a0)};
  endfunction

  for (genvar c = 0; c < 4; c++) begin : g_col
    // subbytes on column c
    sbox_word u_sbox (
      .x (state_in[127-32*c -: 32]),
      .y (sb_col[c])
    );

    // row r takes the byte r columns to the right
    assign sr_col[c] = {sb_col[c][31:24],
                        sb_col[(c+1)%4][23:16],
                        sb_col[(c+2)%4][15:8],
                        sb_col[(c+3)%4][7:0]};

    assign mc_col[c]  = mix_col(sr_col[c]);
    assign ark_col[c] = (last ? sr_col[c] : mc_col[c]) ^ round_key[127-32*c -: 32];
  end

  assign state_out = {ark_col[0], ark_col[1], ark_col[2], ark_col[3]};

endmodule

`default_nettype wire

// ==== verilog/key_expand.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_expand (
  input  aes_pkg::block_t key_in,
  input  aes_pkg::byte_t  rcon,
  output aes_pkg::block_t key_out
);

  aes_pkg::word_t rot;
  aes_pkg::word_t sub;
  aes_pkg::word_t w0;
  aes_pkg::word_t w1;
  aes_pkg::word_t w2;
  aes_pkg::word_t w3;

  assign rot = {key_in[23:0], key_in[31:24]};  // rotword on w[3]

  sbox_word u_sbox (
    .x (rot),
    .y (sub)
  );

  // chained xor across the four words
  assign w0 = sub ^ {rcon, 24'h0} ^ key_in[127:96];
  assign w1 = w0 ^ key_in[95:64];
  assign w2 = w1 ^ key_in[63:32];
  assign w3 = w2 ^ key_in[31:0];

  assign key_out = {w0, w1, w2, w3};

endmodule

`default_nettype wire

// ==== verilog/aes_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_seq (
  input  logic                     CLK,
  input  logic                     rst,
  input  logic                     en,
  input  logic                     key_rdy,
  input  logic                     data_rdy,
  output aes_ctrl_pkg::round_ctl_t round_ctl,
  output logic                     key_vld,
  output logic                     busy,
  output logic                     dout_vld
);

  localparam logic [3:0] last_mid = 4'(aes_pkg::num_rounds - 1);

  aes_ctrl_pkg::seq_state_e state;
  aes_ctrl_pkg::seq_state_e state_nxt;
  aes_ctrl_pkg::dp_op_e     op;
  logic [3:0]               rnd_cnt;  // current middle round
  aes_pkg::byte_t           rcon;

  // --------------------
  // opcode decode
  // --------------------
  always_comb begin
    op        = aes_ctrl_pkg::op_hold;
    state_nxt = state;
    case (state)
      aes_ctrl_pkg::st_idle: begin
        if (key_rdy) begin
          op = aes_ctrl_pkg::op_key_load;  // key wins over data
        end else if (data_rdy && !busy) begin
          op        = aes_ctrl_pkg::op_data_load;
          state_nxt = aes_ctrl_pkg::st_round;
        end
      end
      aes_ctrl_pkg::st_round: begin
        op = aes_ctrl_pkg::op_round;
        if (rnd_cnt == last_mid) state_nxt = aes_ctrl_pkg::st_final;
      end
      aes_ctrl_pkg::st_final: begin
        op        = aes_ctrl_pkg::op_final;
        state_nxt = aes_ctrl_pkg::st_idle;
      end
      default: state_nxt = aes_ctrl_pkg::st_idle;
    endcase
  end

  assign round_ctl = '{op: op, rcon: rcon};

  // --------------------
  // state and flags
  // --------------------
  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      state    <= aes_ctrl_pkg::st_idle;
      rnd_cnt  <= '0;
      rcon     <= aes_pkg::rcon_init;
      key_vld  <= 1'b0;
      busy     <= 1'b0;
      dout_vld <= 1'b0;
    end else if (en) begin
      state <= state_nxt;
      if (op == aes_ctrl_pkg::op_data_load) begin
        rnd_cnt <= 4'd1;
        rcon    <= aes_pkg::rcon_init;
      end else if (op == aes_ctrl_pkg::op_round) begin
        rnd_cnt <= rnd_cnt + 4'd1;
        rcon    <= aes_pkg::xtime(rcon);  // 36 left for the final round
      end
      key_vld  <= (op == aes_ctrl_pkg::op_key_load);
      busy     <= (op == aes_ctrl_pkg::op_data_load) || (state != aes_ctrl_pkg::st_idle);
      dout_vld <= (state == aes_ctrl_pkg::st_final);
    end
  end

  // a start request during a block is dropped
  a_data_while_busy: assert property (@(posedge CLK) disable iff (rst)
    en && busy |-> !data_rdy)
    else $warning("data_rdy ignored while busy");

  // a new key would corrupt the round keys in flight
  a_key_while_busy: assert property (@(posedge CLK) disable iff (rst)
    en && busy |-> !key_rdy)
    else $error("key_rdy while busy");

endmodule

`default_nettype wire

// ==== verilog/aes_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_datapath (
  input  logic                     CLK,
  input  logic                     rst,
  input  logic                     en,
  input  aes_ctrl_pkg::round_ctl_t round_ctl,
  input  aes_pkg::block_t          key_in,
  input  aes_pkg::block_t          din,
  output aes_pkg::block_t          dout
);

  aes_pkg::block_t key_r;      // cipher key
  aes_pkg::block_t rkey_r;     // round key of the last round done
  aes_pkg::block_t state_r;
  aes_pkg::block_t rkey_next;
  aes_pkg::block_t round_out;
  logic            last_round;

  assign last_round = (round_ctl.op == aes_ctrl_pkg::op_final);

  key_expand u_key_expand (
    .key_in  (rkey_r),
    .rcon    (round_ctl.rcon),
    .key_out (rkey_next)
  );

  aes_round u_round (
    .state_in  (state_r),
    .round_key (rkey_next),
    .last      (last_round),
    .state_out (round_out)
  );

  // --------------------
  // key registers
  // --------------------
  always_ff @(posedge CLK) begin
    if (en) begin
      case (round_ctl.op)
        aes_ctrl_pkg::op_key_load:  key_r  <= key_in;
        aes_ctrl_pkg::op_data_load: rkey_r <= key_r;  // round 0 key
        aes_ctrl_pkg::op_round,
        aes_ctrl_pkg::op_final:     rkey_r <= rkey_next;
        default:                    rkey_r <= rkey_r;
      endcase
    end
  end

  // state, also the held ciphertext
  always_ff @(posedge CLK or posedge rst) begin
    if (rst) begin
      state_r <= '0;
    end else if (en) begin
      case (round_ctl.op)
        aes_ctrl_pkg::op_data_load: state_r <= din ^ key_r;
        aes_ctrl_pkg::op_round,
        aes_ctrl_pkg::op_final:     state_r <= round_out;
        default:                    state_r <= state_r;
      endcase
    end
  end

  assign dout = state_r;

endmodule

`default_nettype wire

// ==== verilog/aes_enc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_enc_top (
  input  logic              CLK,
  input  logic              rst,
  input  logic              en,
  input  aes_pkg::blk_req_t key_req,
  input  aes_pkg::blk_req_t data_req,
  output logic              key_vld,
  output logic              busy,
  output aes_pkg::blk_rsp_t dout_rsp
);

  aes_ctrl_pkg::round_ctl_t round_ctl;
  logic                     dout_vld;
  aes_pkg::block_t          ct_blk;   // ciphertext

  // --------------------
  // sequencer
  // --------------------
  aes_seq u_seq (
    .CLK       (CLK),
    .rst       (rst),
    .en        (en),
    .key_rdy   (key_req.rdy),
    .data_rdy  (data_req.rdy),
    .round_ctl (round_ctl),
    .key_vld   (key_vld),
    .busy      (busy),
    .dout_vld  (dout_vld)
  );

  // round datapath
  aes_datapath u_datapath (
    .CLK       (CLK),
    .rst       (rst),
    .en        (en),
    .round_ctl (round_ctl),
    .key_in    (key_req.blk),
    .din       (data_req.blk),
    .dout      (ct_blk)
  );

  assign dout_rsp = '{vld: dout_vld, blk: ct_blk};

endmodule

`default_nettype wire

// ==== verif/aes_vectors.svh ====
`ifndef aes_vectors_svh
`define aes_vectors_svh

// columns: cipher key, plaintext, expected ciphertext
// byte 0 of each block is the leftmost hex pair
typedef struct packed {
  aes_pkg::block_t key;
  aes_pkg::block_t pt;
  aes_pkg::block_t ct;
} vec_t;

localparam int num_vec = 4;

localparam vec_t vectors [num_vec] = '{
  // FIPS-197 appendix B
  '{key: 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
    pt:  128'h3243f6a8_885a308d_313198a2_e0370734,
    ct:  128'h3925841d_02dc09fb_dc118597_196a0b32},
  // FIPS-197 appendix C.1
  '{key: 128'h00010203_04050607_08090a0b_0c0d0e0f,
    pt:  128'h00112233_44556677_8899aabb_ccddeeff,
    ct:  128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a},
  // all-zero key and plaintext
  '{key: 128'h00000000_00000000_00000000_00000000,
    pt:  128'h00000000_00000000_00000000_00000000,
    ct:  128'h66e94bd4_ef8a2c3b_884cfa59_ca342b2e},
  // all-ones key, zero plaintext (NIST varkey KAT, last entry)
  '{key: 128'hffffffff_ffffffff_ffffffff_ffffffff,
    pt:  128'h00000000_00000000_00000000_00000000,
    ct:  128'ha1f6258c_877d5fcd_89644845_38bfc92c}
};

`endif

// ==== verif/tb_aes_enc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aes_enc;

  `include "aes_vectors.svh"

  localparam int max_cycles = 4 * (num_vec * 16 + 20);
  localparam int latency    = 11;  // enabled edges counting the start edge

  logic              CLK;
  logic              rst;
  logic              en;
  aes_pkg::blk_req_t key_req;
  aes_pkg::blk_req_t data_req;
  logic              key_vld;
  logic              busy;
  aes_pkg::blk_rsp_t dout_rsp;

  int cycle_cnt    = 0;
  int edge_cnt     = 0;  // edges seen with en high
  int err_cnt      = 0;
  int test_errs    = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  bit pause_en     = 1'b0;  // random en gaps

  aes_enc_top i_dut (
    .CLK      (CLK),
    .rst      (rst),
    .en       (en),
    .key_req  (key_req),
    .data_req (data_req),
    .key_vld  (key_vld),
    .busy     (busy),
    .dout_rsp (dout_rsp)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // watchdog
  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------
  // helpers
  // --------------------
  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // one clock with inputs changed 2 ns after the edge
  task automatic step();
    @(posedge CLK);
    if (en) edge_cnt++;
    #2;
    if (pause_en) en = ($urandom % 3) != 0;  // low about one edge in three
  endtask

  task automatic load_key(input aes_pkg::block_t key);
    int start;
    start   = edge_cnt;
    key_req = '{rdy: 1'b1, blk: key};
    do step(); while (edge_cnt == start);
    key_req.rdy = 1'b0;
    check("key_vld", 128'(key_vld), 128'(1'b1));
    start = edge_cnt;
    do step(); while (edge_cnt == start);
    check("key_vld", 128'(key_vld), 128'(1'b0));  // one cycle only
  endtask

  // start a block and wait for vld with an optional rdy poke mid-run
  task automatic run_block(input aes_pkg::block_t pt, input bit poke,
                           output int lat, output aes_pkg::block_t ct);
    int start;
    int waited;
    start    = edge_cnt;
    waited   = 0;
    data_req = '{rdy: 1'b1, blk: pt};
    do step(); while (edge_cnt == start);
    data_req.rdy = 1'b0;
    while (!dout_rsp.vld && waited < 4 * latency) begin
      check("busy", 128'(busy), 128'(1'b1));
      step();
      waited++;
      if (poke && waited == 4) data_req = '{rdy: 1'b1, blk: ~pt};
      if (poke && waited == 5) data_req.rdy = 1'b0;
    end
    if (!dout_rsp.vld) begin
      $display("dout_rsp.vld did not rise within %0d cycles of the start", 4 * latency);
      err_cnt++;
    end
    check("busy", 128'(busy), 128'(1'b1));  // still high in the vld cycle
    lat = edge_cnt - start;
    ct  = dout_rsp.blk;
  endtask

  task automatic wait_idle(output int n);
    n = 0;
    while (busy && n < 16) begin
      step();
      n++;
    end
    if (busy) begin
      $display("busy stayed high after the result");
      err_cnt++;
    end
    check("dout_rsp.vld", 128'(dout_rsp.vld), 128'(1'b0));
  endtask

  task automatic hold_result(input aes_pkg::block_t exp, input int n);
    repeat (n) begin
      step();
      check("dout_rsp.blk", dout_rsp.blk, exp);
      check("dout_rsp.vld", 128'(dout_rsp.vld), 128'(1'b0));
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_cnt == test_errs) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - test_errs);
    end
    test_errs = err_cnt;
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    int              lat;
    int              n;
    aes_pkg::block_t ct;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'hc178_86b7));
    rst      = 1'b1;
    en       = 1'b1;
    key_req  = '0;
    data_req = '0;
    repeat (2) step();
    rst = 1'b0;

    check("key_vld", 128'(key_vld), 128'(1'b0));
    check("busy", 128'(busy), 128'(1'b0));
    check("dout_rsp.vld", 128'(dout_rsp.vld), 128'(1'b0));
    check("dout_rsp.blk", dout_rsp.blk, 128'h0);
    report_test("reset state");

    // known answers with latency
    for (int i = 0; i < num_vec; i++) begin
      load_key(vectors[i].key);
      run_block(vectors[i].pt, 1'b0, lat, ct);
      check("vld latency", 128'(lat), 128'(latency));
      check("dout_rsp.blk", ct, vectors[i].ct);
      wait_idle(n);
      report_test($sformatf("vector %0d", i));
    end

    // second start right after busy falls
    load_key(vectors[0].key);
    run_block(vectors[0].pt, 1'b0, lat, ct);
    check("dout_rsp.blk", ct, vectors[0].ct);
    wait_idle(n);
    check("busy cycles after vld", 128'(n), 128'(1));
    run_block(vectors[0].pt, 1'b0, lat, ct);
    check("vld latency", 128'(lat), 128'(latency));
    check("dout_rsp.blk", ct, vectors[0].ct);
    wait_idle(n);
    report_test("back-to-back");

    for (int i = 0; i < num_vec; i++) begin
      load_key(vectors[i].key);
      pause_en = 1'b1;
      run_block(vectors[i].pt, 1'b0, lat, ct);
      pause_en = 1'b0;
      en       = 1'b1;
      check("vld latency", 128'(lat), 128'(latency));
      check("dout_rsp.blk", ct, vectors[i].ct);
      wait_idle(n);
    end
    report_test("enable pause");

    // rdy during busy is dropped and the result held
    load_key(vectors[1].key);
    run_block(vectors[1].pt, 1'b1, lat, ct);
    check("vld latency", 128'(lat), 128'(latency));
    check("dout_rsp.blk", ct, vectors[1].ct);
    data_req = '{rdy: 1'b1, blk: ~vectors[1].pt};  // sampled in the vld cycle
    wait_idle(n);
    data_req.rdy = 1'b0;
    check("busy cycles after vld", 128'(n), 128'(1));
    hold_result(vectors[1].ct, 4);
    report_test("busy and held result");

    $display("%0d tests, %0d failed, %0d errors, %0d cycles",
             tests_run, tests_failed, err_cnt, cycle_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verif
verilog/aes_pkg.sv
verilog/aes_ctrl_pkg.sv
verilog/gf_inv8.sv
verilog/sbox_word.sv
verilog/aes_round.sv
verilog/key_expand.sv
verilog/aes_seq.sv
verilog/aes_datapath.sv
verilog/aes_enc_top.sv
verif/tb_aes_enc.sv

// ==== Makefile ====
# Verilator build and run for the AES-128 encryption core

VERILATOR ?= verilator
TOP       ?= tb_aes_enc
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
